/* alu16_top.f */
logic/alu_pkg.sv
logic/alu_slice.sv
logic/carry_lookahead.sv
logic/op_decode.sv
logic/alu_execute.sv
logic/result_stage.sv
logic/alu16_top.sv
tests/alu16_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the ALU testbench with Verilator and runs it, the exit status is the verdict
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f alu16_top.f \
	--top-module alu16_tb \
	--Mdir obj_dir \
	-o alu16_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/alu16_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0

/* tests/alu16_tb.sv */
// Random testbench for the 16-bit ALU with an in-order reference model
// Build with timing support, outputs are checked at the falling clock edge
`default_nettype none

module alu16_tb;
	import alu_pkg::*;

	localparam int clk_half = 20;
	localparam int drive_delay = 5;
	localparam int reset_cycles = 5;
	localparam int n_ops = 500;
	// 500 operations, about one idle cycle in 16, reset and a short drain fit well below this
	localparam int max_cycles = 700;

	// What the model expects one operation to leave in the result stage
	typedef struct packed {
		logic [15:0] y;
		logic carry;
		logic writes_carry;
		logic check_y;
	} expect_t;

	logic clk;
	logic reset;
	logic op_valid;
	alu_op_t op;
	logic [15:0] a;
	logic [15:0] b;
	logic result_valid;
	logic [15:0] y;
	logic carry;
	logic zero;
	logic negative;
	logic all_ones;

	expect_t expected_q[$];
	expect_t cur_exp;
	logic [31:0] rng_state;
	// Flag as the issue side sees it, one operation ahead of the outputs
	logic model_carry;
	// Flag as it should appear on the carry output
	logic out_carry;
	logic stage1;
	logic stage2;
	logic exp_valid;
	int cycle_count;
	int issued_count;
	int checked_count;

	alu16_top DUT (
		.clk          (clk),
		.reset        (reset),
		.op_valid     (op_valid),
		.op           (op),
		.a            (a),
		.b            (b),
		.result_valid (result_valid),
		.y            (y),
		.carry        (carry),
		.zero         (zero),
		.negative     (negative),
		.all_ones     (all_ones)
	);

	always #clk_half clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Result and new flag value of one operation, worked out from plain integer arithmetic
	function automatic expect_t model_op(input alu_op_t code, input logic [15:0] x,
		input logic [15:0] w, input logic c);
		expect_t e;
		logic [16:0] wide;
		e.y = 16'h0000;
		e.carry = c;
		e.writes_carry = 1'b0;
		e.check_y = 1'b1;
		wide = 17'd0;
		case (code)
			op_add: begin
				wide = {1'b0, x} + {1'b0, w};
				e.y = wide[15:0];
				e.carry = wide[16];
				e.writes_carry = 1'b1;
			end
			op_adc: begin
				wide = {1'b0, x} + {1'b0, w} + {16'd0, c};
				e.y = wide[15:0];
				e.carry = wide[16];
				e.writes_carry = 1'b1;
			end
			op_sub: begin
				e.y = x - w;
				e.carry = (x >= w);
				e.writes_carry = 1'b1;
			end
			op_sbc: begin
				// Borrow in is the inverted flag, a negative 17-bit difference means borrow out
				wide = {1'b0, x} - {1'b0, w} - {16'd0, ~c};
				e.y = wide[15:0];
				e.carry = ~wide[16];
				e.writes_carry = 1'b1;
			end
			op_inc: begin
				wide = {1'b0, x} + 17'd1;
				e.y = wide[15:0];
				e.carry = wide[16];
				e.writes_carry = 1'b1;
			end
			op_dec: begin
				e.y = x - 16'd1;
				e.carry = (x != 16'd0);
				e.writes_carry = 1'b1;
			end
			op_cmp: begin
				e.y = x - w - 16'd1;
				e.carry = (x > w);
				e.writes_carry = 1'b1;
			end
			op_and: e.y = x & w;
			op_or: e.y = x | w;
			op_xor: e.y = x ^ w;
			op_nota: e.y = ~x;
			op_passb: e.y = w;
			// The nop result is not defined, only its strobe and the untouched flag count
			default: e.check_y = 1'b0;
		endcase
		return e;
	endfunction

	task automatic abort_run();
		$display("Something failed");
		$fatal;
	endtask

	task automatic check_word(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		assert (actual === expected) else begin
			$display("ERROR time %0t: %s expected %h actual %h", $time, name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		assert (actual === expected) else begin
			$display("ERROR time %0t: %s expected %b actual %b", $time, name, expected, actual);
			abort_run();
		end
	endtask

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("Timeout after %0d cycles, the results never all came out", cycle_count);
			abort_run();
		end
	end

	// An op_valid seen here is sampled at the next rising edge and shows two falling edges on
	always @(negedge clk) begin
		// Nothing has been clocked into the DUT before the first rising edge
		if (cycle_count > 0) begin
			exp_valid = stage2;
			stage2 = stage1;
			stage1 = op_valid;
			check_bit("result_valid", exp_valid, result_valid);
			if (exp_valid) begin
				if (expected_q.size() == 0) begin
					$display("A result came out with no operation waiting for it");
					abort_run();
				end else begin
					cur_exp = expected_q.pop_front();
					checked_count = checked_count + 1;
					if (cur_exp.writes_carry) begin
						out_carry = cur_exp.carry;
					end
					if (cur_exp.check_y) begin
						check_word("y", cur_exp.y, y);
						check_bit("zero", (cur_exp.y == 16'h0000), zero);
						check_bit("negative", cur_exp.y[15], negative);
						check_bit("all_ones", (cur_exp.y == 16'hffff), all_ones);
					end
				end
			end
			check_bit("carry", out_carry, carry);
		end
	end

	initial begin
		logic [31:0] r1;
		logic [31:0] r2;
		logic [3:0] code;
		int chain_left;
		expect_t issue_exp;
		clk = 1'b0;
		reset = 1'b1;
		op_valid = 1'b0;
		op = op_nop;
		a = 16'h0000;
		b = 16'h0000;
		rng_state = 32'd44917;
		model_carry = 1'b0;
		out_carry = 1'b0;
		stage1 = 1'b0;
		stage2 = 1'b0;
		exp_valid = 1'b0;
		cycle_count = 0;
		issued_count = 0;
		checked_count = 0;
		chain_left = 0;
		repeat (reset_cycles) @(posedge clk);
		#drive_delay;
		reset = 1'b0;
		while (issued_count < n_ops) begin
			@(posedge clk);
			#drive_delay;
			rng_state = xorshift32(rng_state);
			r1 = rng_state;
			rng_state = xorshift32(rng_state);
			r2 = rng_state;
			a = r2[15:0];
			b = r2[31:16];
			// Corner operands so carries out of the top and the zero flag get exercised
			if (r1[11:9] == 3'd0) begin
				a = 16'hffff;
			end else if (r1[11:9] == 3'd1) begin
				a = 16'h0000;
			end
			if (chain_left == 0 && r1[7:4] == 4'd0) begin
				chain_left = 3 + int'(r1[14:13]);
			end
			if (chain_left > 0) begin
				op = r1[15] ? op_sbc : op_adc;
				chain_left = chain_left - 1;
				op_valid = 1'b1;
			end else if (r1[3:0] == 4'd0) begin
				op_valid = 1'b0;
			end else begin
				code = 4'(r1[31:16] % 16'd13);
				op = alu_op_t'(code);
				op_valid = 1'b1;
			end
			// Equal operands give zero on sub and all ones on cmp
			if ((op == op_sub || op == op_cmp || op == op_sbc) && r1[12]) begin
				b = a;
			end
			if (op_valid) begin
				issue_exp = model_op(op, a, b, model_carry);
				model_carry = issue_exp.carry;
				expected_q.push_back(issue_exp);
				issued_count = issued_count + 1;
			end
		end
		@(posedge clk);
		#drive_delay;
		op_valid = 1'b0;
		while (checked_count < issued_count) begin
			@(posedge clk);
		end
		// A few quiet cycles make sure no stray strobe follows the last result
		repeat (3) @(posedge clk);
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

/* logic/alu16_top.sv */
// Two-stage 16-bit ALU, result and flags one cycle after the sampling edge
// No handshake, one operation per cycle with op_valid high
`default_nettype none

module alu16_top (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        op_valid,
	input  alu_pkg::alu_op_t            op,
	input  logic [alu_pkg::data_w-1:0]  a,
	input  logic [alu_pkg::data_w-1:0]  b,
	output logic                        result_valid,
	output logic [alu_pkg::data_w-1:0]  y,
	output logic                        carry,
	output logic                        zero,
	output logic                        negative,
	output logic                        all_ones
);
	import alu_pkg::*;

	decoded_op_t dec;
	exec_result_t ex;

	op_decode u_decode (
		.clk      (clk),
		.reset    (reset),
		.op_valid (op_valid),
		.op       (op),
		.a        (a),
		.b        (b),
		.dec      (dec)
	);

	// The carry port doubles as the flag fed back into execute
	alu_execute u_execute (
		.dec        (dec),
		.carry_flag (carry),
		.ex         (ex)
	);

	result_stage u_result (
		.clk          (clk),
		.reset        (reset),
		.ex           (ex),
		.result_valid (result_valid),
		.y            (y),
		.carry_flag   (carry),
		.zero         (zero),
		.negative     (negative),
		.all_ones     (all_ones)
	);

endmodule

`default_nettype wire

/* logic/result_stage.sv */
// Result register and carry flag, outputs hold until the next valid result
// The carry flag changes only on arithmetic operations
`default_nettype none

module result_stage (
	input  logic                        clk,
	input  logic                        reset,
	input  alu_pkg::exec_result_t       ex,
	output logic                        result_valid,
	output logic [alu_pkg::data_w-1:0]  y,
	output logic                        carry_flag,
	output logic                        zero,
	output logic                        negative,
	output logic                        all_ones
);
	import alu_pkg::*;

	// One-cycle strobe for every operation that left the decode stage
	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= ex.valid;
		end
	end

	// Result and its flags, cleared by reset so zero starts low as well
	always_ff @(posedge clk) begin
		if (reset) begin
			y <= '0;
			zero <= 1'b0;
			negative <= 1'b0;
			all_ones <= 1'b0;
		end else if (ex.valid) begin
			y <= ex.y;
			zero <= (ex.y == '0);
			negative <= ex.y[data_w-1];
			all_ones <= ex.all_ones;
		end
	end

	// Written at the same edge the next operation reads it, so carry chains run back to back
	always_ff @(posedge clk) begin
		if (reset) begin
			carry_flag <= 1'b0;
		end else if (ex.valid && ex.writes_carry) begin
			carry_flag <= ex.carry;
		end
	end

endmodule

`default_nettype wire

/* logic/alu_execute.sv */
// Combinational 16-bit execute stage, four slices under one look-ahead carry unit
// The carry flag must come from the result register of the same pipeline
`default_nettype none

module alu_execute (
	input  alu_pkg::decoded_op_t  dec,
	input  logic                  carry_flag,
	output alu_pkg::exec_result_t ex
);
	import alu_pkg::*;

	// Carry into slice 0 in true sense
	logic cin;
	// Carry into slice 0, active low
	logic cn0_n;
	// Active-low carries from the carry unit into slices 1 to 3
	logic cx_n;
	logic cy_n;
	logic cz_n;
	// Active-low carry into each slice, slice 0 from cin and the rest from the carry unit
	logic [n_slices-1:0] slice_cn_n;
	logic [n_slices-1:0] g_n;
	logic [n_slices-1:0] p_n;
	logic [n_slices-1:0] aeqb;
	logic [data_w-1:0] f;
	logic co_n;

	always_comb begin
		case (dec.carry_src)
			cin_forced: cin = 1'b1;
			cin_flag: cin = carry_flag;
			cin_flag_n: cin = ~carry_flag;
			default: cin = 1'b0;
		endcase
	end

	assign cn0_n = ~cin;
	assign slice_cn_n = {cz_n, cy_n, cx_n, cn0_n};

	// Slice i handles bits i*4 up to i*4+3, the ripple carry out is left open
	for (genvar i = 0; i < n_slices; i++) begin : g_slice
		alu_slice u_slice (
			.a     (dec.a[i*slice_w +: slice_w]),
			.b     (dec.b[i*slice_w +: slice_w]),
			.s     (dec.sel),
			.m     (dec.mode),
			.cn_n  (slice_cn_n[i]),
			.f     (f[i*slice_w +: slice_w]),
			.cn4_n (),
			.g_n   (g_n[i]),
			.p_n   (p_n[i]),
			.aeqb  (aeqb[i])
		);
	end

	carry_lookahead u_cla (
		.cn_n (cn0_n),
		.g_n  (g_n),
		.p_n  (p_n),
		.cx_n (cx_n),
		.cy_n (cy_n),
		.cz_n (cz_n),
		.co_n (co_n)
	);

	always_comb begin
		ex.y = f;
		// Meaningless in logic mode, the result stage ignores it there
		ex.carry = ~co_n;
		ex.all_ones = &aeqb;
		ex.writes_carry = dec.writes_carry;
		ex.valid = dec.valid;
	end

endmodule

`default_nettype wire

/* logic/op_decode.sv */
// Decode register, one operation per cycle with op_valid high, no back-pressure
// Undefined operation codes behave like op_nop
`default_nettype none

module op_decode (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        op_valid,
	input  alu_pkg::alu_op_t            op,
	input  logic [alu_pkg::data_w-1:0]  a,
	input  logic [alu_pkg::data_w-1:0]  b,
	output alu_pkg::decoded_op_t        dec
);
	import alu_pkg::*;

	decoded_op_t dec_d;

	always_comb begin
		dec_d.a = a;
		dec_d.b = b;
		dec_d.valid = op_valid;
		// A nop passes A through in logic mode and leaves the flag alone
		dec_d.sel = sel_amo;
		dec_d.mode = 1'b1;
		dec_d.carry_src = cin_none;
		dec_d.writes_carry = 1'b0;
		case (op)
			op_add, op_adc, op_sub, op_sbc, op_inc, op_dec, op_cmp: begin
				dec_d.mode = 1'b0;
				dec_d.writes_carry = 1'b1;
				case (op)
					op_add: dec_d.sel = sel_apb;
					// Add with carry and subtract with borrow both feed the flag straight in
					op_adc: begin
						dec_d.sel = sel_apb;
						dec_d.carry_src = cin_flag;
					end
					// Two's complement needs the forced carry
					op_sub: begin
						dec_d.sel = sel_amb;
						dec_d.carry_src = cin_forced;
					end
					op_sbc: begin
						dec_d.sel = sel_amb;
						dec_d.carry_src = cin_flag;
					end
					op_inc: begin
						dec_d.sel = sel_a;
						dec_d.carry_src = cin_forced;
					end
					op_dec: dec_d.sel = sel_amo;
					// No carry in leaves A minus B minus 1
					default: dec_d.sel = sel_amb;
				endcase
			end
			op_and: dec_d.sel = sel_and;
			op_or: dec_d.sel = sel_or;
			op_xor: dec_d.sel = sel_xor;
			op_nota: dec_d.sel = sel_a;
			op_passb: dec_d.sel = sel_b;
			default: dec_d.sel = sel_amo;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			dec.valid <= 1'b0;
			dec.writes_carry <= 1'b0;
		end else begin
			dec <= dec_d;
		end
	end

endmodule

`default_nettype wire

/* logic/carry_lookahead.sv */
// 74182-style carry unit for four slices, active-low carries throughout
// Takes the slice group terms exactly as the slices drive them
`default_nettype none

module carry_lookahead (
	input  logic       cn_n,
	input  logic [3:0] g_n,
	input  logic [3:0] p_n,
	output logic       cx_n,
	output logic       cy_n,
	output logic       cz_n,
	output logic       co_n
);

	// Group generate and propagate back in true sense
	logic [3:0] gg;
	logic [3:0] pp;

	assign gg = ~g_n;
	assign pp = ~p_n;

	// Carry into slice 1
	assign cx_n = gg[0] | (pp[0] & cn_n);

	// Carry into slice 2
	assign cy_n = gg[1] | (pp[1] & gg[0]) | (pp[1] & pp[0] & cn_n);

	// Carry into slice 3
	assign cz_n = gg[2] | (pp[2] & gg[1]) | (pp[2] & pp[1] & gg[0])
		| (pp[2] & pp[1] & pp[0] & cn_n);

	// Carry out of slice 3, still active low
	assign co_n = gg[3] | (pp[3] & gg[2]) | (pp[3] & pp[2] & gg[1])
		| (pp[3] & pp[2] & pp[1] & gg[0])
		| (pp[3] & pp[2] & pp[1] & pp[0] & cn_n);

endmodule

`default_nettype wire

/* logic/alu_slice.sv */
// One 4-bit 74181-style slice with active-high data and active-low carries
// No timing model and no open-collector A=B output
`default_nettype none

module alu_slice (
	input  logic [3:0] a,
	input  logic [3:0] b,
	input  logic [3:0] s,
	input  logic       m,
	input  logic       cn_n,
	output logic [3:0] f,
	output logic       cn4_n,
	output logic       g_n,
	output logic       p_n,
	output logic       aeqb
);

	// Per-bit generate and propagate of the complemented operands
	// Working on complemented data keeps every carry active low
	logic [3:0] g_bit;
	logic [3:0] p_bit;
	// Half sum of each bit before the carry is folded in
	logic [3:0] half;
	// Active-low carry into each bit position
	logic [3:0] c_n;
	// Active-high carry seen by the sum XOR, forced high in logic mode
	logic [3:0] bit_c;
	logic grp_g;
	logic grp_p;

	// S0 and S1 steer B into the generate term
	assign g_bit = ~(a | (b & {4{s[0]}}) | (~b & {4{s[1]}}));
	// S2 and S3 steer B into the propagate term
	assign p_bit = ~((a & ~b & {4{s[2]}}) | (a & b & {4{s[3]}}));
	assign half = g_bit ^ p_bit;

	// Look-ahead carries inside the slice, each one two logic levels deep
	assign c_n[0] = cn_n;
	assign c_n[1] = g_bit[0] | (p_bit[0] & cn_n);
	assign c_n[2] = g_bit[1] | (p_bit[1] & g_bit[0]) | (p_bit[1] & p_bit[0] & cn_n);
	assign c_n[3] = g_bit[2] | (p_bit[2] & g_bit[1]) | (p_bit[2] & p_bit[1] & g_bit[0])
		| (p_bit[2] & p_bit[1] & p_bit[0] & cn_n);

	// Mode high kills every carry so the slice gives pure logic functions
	assign bit_c = {4{m}} | ~c_n;
	assign f = half ^ bit_c;

	// Group terms for the external carry unit
	assign grp_g = g_bit[3] | (p_bit[3] & g_bit[2]) | (p_bit[3] & p_bit[2] & g_bit[1])
		| (p_bit[3] & p_bit[2] & p_bit[1] & g_bit[0]);
	assign grp_p = &p_bit;
	assign g_n = ~grp_g;
	assign p_n = ~grp_p;

	// Ripple carry out, used when slices are chained without the carry unit
	assign cn4_n = grp_g | (grp_p & cn_n);

	// High when all four outputs are one, as after A minus B minus 1 with A equal to B
	assign aeqb = &f;

endmodule

`default_nettype wire

/* logic/alu_pkg.sv */
// Shared types and constants for the 16-bit bitslice ALU
// The width is fixed by four 4-bit slices and one look-ahead carry unit
`default_nettype none

package alu_pkg;

	// Datapath geometry
	localparam int data_w = 16;
	localparam int slice_w = 4;
	localparam int n_slices = 4;

	// Slice select codes with active-high data
	// In arithmetic mode, A plus B
	localparam logic [3:0] sel_apb = 4'b1001;
	// In arithmetic mode, A minus B minus 1, or A minus B with carry in
	localparam logic [3:0] sel_amb = 4'b0110;
	// In arithmetic mode, A, or A plus 1 with carry in
	// In logic mode the same code gives not A
	localparam logic [3:0] sel_a = 4'b0000;
	// In arithmetic mode, A minus 1, or A with carry in
	// In logic mode the same code gives A
	localparam logic [3:0] sel_amo = 4'b1111;
	// Logic mode codes
	localparam logic [3:0] sel_and = 4'b1011;
	localparam logic [3:0] sel_or = 4'b1110;
	localparam logic [3:0] sel_xor = 4'b0110;
	localparam logic [3:0] sel_b = 4'b1010;

	// Operation codes seen at the ALU input
	typedef enum logic [3:0] {
		op_add = 4'd0,
		op_adc = 4'd1,
		op_sub = 4'd2,
		op_sbc = 4'd3,
		op_inc = 4'd4,
		op_dec = 4'd5,
		op_cmp = 4'd6,
		op_and = 4'd7,
		op_or = 4'd8,
		op_xor = 4'd9,
		op_nota = 4'd10,
		op_passb = 4'd11,
		op_nop = 4'd12
	} alu_op_t;

	// Carry into slice 0, in active-high sense before inversion
	typedef enum logic [1:0] {
		cin_none = 2'd0,
		cin_forced = 2'd1,
		cin_flag = 2'd2,
		cin_flag_n = 2'd3
	} carry_src_t;

	// Contents of the decode register
	typedef struct packed {
		logic [data_w-1:0] a;
		logic [data_w-1:0] b;
		logic [3:0] sel;
		logic mode;
		carry_src_t carry_src;
		logic writes_carry;
		logic valid;
	} decoded_op_t;

	// Combinational result handed to the result stage
	typedef struct packed {
		logic [data_w-1:0] y;
		// High means carry out, or no borrow for subtraction
		logic carry;
		logic all_ones;
		logic writes_carry;
		logic valid;
	} exec_result_t;

endpackage

`default_nettype wire
